//--- filelist.f
br_pkg.sv
rs_dispatch_itf.sv
br_issue_itf.sv
br_dispatch.sv
br_rs.sv
fu_br.sv
phys_regfile.sv
br_unit_top.sv
br_unit_assertions.sv
tb_br_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build the branch unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_br_unit -f filelist.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_br_unit)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

//--- tb_br_unit.sv
`timescale 1ns/1ps

module tb_br_unit;
    import br_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TESTS       = 5;
    localparam int RS_DEPTH        = 4;
    localparam int WAIT_LIMIT      = 100;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

    logic                clk;
    logic                rst;
    logic                in_valid;
    br_uop_t             in_uop;
    logic                in_ready;
    logic                ext_wr_valid;
    logic [PHY_W-1:0]    ext_wr_phy;
    logic [XLEN-1:0]     ext_wr_value;
    logic                res_valid;
    logic [ROB_ID_W-1:0] res_rob_id;
    logic                res_taken;
    logic [XLEN-1:0]     res_target;
    logic                res_mispredict;

    // reference model state
    logic [XLEN-1:0]     reg_val [64];
    logic                exp_pending [32];
    logic                exp_taken [32];
    logic [XLEN-1:0]     exp_target [32];
    logic                exp_mis [32];
    logic [ROB_ID_W-1:0] next_rob;
    int                  errors;
    int                  results_seen;
    int                  tests_passed;
    int                  tests_failed;
    int                  test_errors_start;

    br_unit_top i_br_unit_top (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_uop         (in_uop),
        .in_ready       (in_ready),
        .ext_wr_valid   (ext_wr_valid),
        .ext_wr_phy     (ext_wr_phy),
        .ext_wr_value   (ext_wr_value),
        .res_valid      (res_valid),
        .res_rob_id     (res_rob_id),
        .res_taken      (res_taken),
        .res_target     (res_target),
        .res_mispredict (res_mispredict)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////////////

    function automatic void branch_outcome(
        input  br_op_t          op,
        input  logic [XLEN-1:0] a,
        input  logic [XLEN-1:0] b,
        input  logic [XLEN-1:0] pc,
        input  logic [XLEN-1:0] imm,
        output logic            taken,
        output logic [XLEN-1:0] target
    );
        logic lt_u;
        logic lt_s;
        lt_u   = a < b;
        // on differing signs the negative one is smaller
        lt_s   = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;
        target = pc + imm;
        case (op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            OP_JAL:  taken = 1'b1;
            default: begin
                taken  = 1'b1;
                target = (a + imm) & ~32'd1;
            end
        endcase
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            if (exp_pending[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_field(
        input string               name,
        input logic [ROB_ID_W-1:0] id,
        input logic [XLEN-1:0]     got,
        input logic [XLEN-1:0]     want
    );
        assert (got === want) else begin
            $display("FAILED %s rob_id %h: got %h, expected %h", name, id, got, want);
            errors++;
        end
    endtask

    // registered results are settled by the falling edge
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            assert (exp_pending[res_rob_id]) else begin
                $display("result for rob_id %h arrived with no branch outstanding",
                         res_rob_id);
                errors++;
            end
            compare_field("res_taken", res_rob_id, XLEN'(res_taken),
                          XLEN'(exp_taken[res_rob_id]));
            compare_field("res_target", res_rob_id, res_target, exp_target[res_rob_id]);
            compare_field("res_mispredict", res_rob_id, XLEN'(res_mispredict),
                          XLEN'(exp_mis[res_rob_id]));
            exp_pending[res_rob_id] = 1'b0;
            results_seen++;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // drivers entered and left on a falling edge
    ////////////////////////////////////////////////////////////////////

    task automatic send_uop(input br_uop_t u);
        int waited;
        waited   = 0;
        in_uop   = u;
        in_valid = 1'b1;
        while (!in_ready && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        assert (in_ready) else begin
            $display("dispatch never accepted rob_id %h", u.rob_id);
            errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic ext_write(input logic [PHY_W-1:0] phy, input logic [XLEN-1:0] value);
        ext_wr_valid = 1'b1;
        ext_wr_phy   = phy;
        ext_wr_value = value;
        @(negedge clk);
        ext_wr_valid = 1'b0;
    endtask

    task automatic dispatch_branch(
        input  br_op_t              op,
        input  logic [PHY_W-1:0]    rs1,
        input  logic [PHY_W-1:0]    rs2,
        input  logic [PHY_W-1:0]    rd,
        output logic [ROB_ID_W-1:0] id
    );
        br_uop_t         u;
        logic [11:0]     imm12;
        logic            taken;
        logic [XLEN-1:0] target;
        u         = '0;
        imm12     = 12'($urandom);
        u.rob_id  = next_rob;
        u.op      = op;
        u.rs1_phy = rs1;
        u.rs2_phy = rs2;
        u.rd_phy  = rd;
        u.pc      = $urandom & 32'hffff_fffc;
        u.imm     = {{20{imm12[11]}}, imm12[11:1], 1'b0};
        branch_outcome(op, reg_val[rs1], reg_val[rs2], u.pc, u.imm, taken, target);
        u.predict_taken  = 1'($urandom_range(0, 1));
        // one in four predicted targets is off
        u.predict_target = ($urandom_range(0, 3) == 0) ? $urandom : target;
        id               = next_rob;
        exp_taken[id]    = taken;
        exp_target[id]   = target;
        if (taken) begin
            exp_mis[id] = !u.predict_taken || (target != u.predict_target);
        end else begin
            exp_mis[id] = u.predict_taken;
        end
        exp_pending[id]  = 1'b1;
        next_rob         = next_rob + ROB_ID_W'(1);
        if (((op == OP_JAL) || (op == OP_JALR)) && (rd != '0)) begin
            reg_val[rd] = u.pc + 32'd4;
        end
        send_uop(u);
    endtask

    // conditional branch with rd set stands in for a producer still in flight
    task automatic claim_register(input logic [PHY_W-1:0] phy);
        logic [ROB_ID_W-1:0] id;
        dispatch_branch(OP_BEQ, '0, '0, phy, id);
    endtask

    task automatic wait_result(input logic [ROB_ID_W-1:0] id);
        int cycles;
        cycles = 0;
        while (exp_pending[id] && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        assert (!exp_pending[id]) else begin
            $display("no result for rob_id %h within %0d cycles", id, WAIT_LIMIT);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((count_pending() != 0) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        assert (count_pending() == 0) else begin
            $display("%0d results still missing after %0d cycles", count_pending(), WAIT_LIMIT);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_errors_start) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int                  seed_ret;
        int                  seen_start;
        br_op_t              op;
        logic [PHY_W-1:0]    src;
        logic [PHY_W-1:0]    rs2;
        logic [PHY_W-1:0]    rd;
        logic [ROB_ID_W-1:0] id_a;
        logic [ROB_ID_W-1:0] id_b;

        seed_ret     = $urandom(32'h9173);
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_uop       = '0;
        ext_wr_valid = 1'b0;
        ext_wr_phy   = '0;
        ext_wr_value = '0;
        next_rob     = '0;
        errors       = 0;
        results_seen = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            exp_pending[i] = 1'b0;
        end
        reg_val[0] = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // every physical register gets a known value
        for (int r = 1; r < 64; r++) begin
            reg_val[r] = $urandom;
            ext_write(PHY_W'(r), reg_val[r]);
        end
        test_errors_start = errors;

        // sources 1..31 are never busy
        // links land in 32..47
        for (int i = 0; i < 16; i++) begin
            op  = (i < 8) ? br_op_t'(3'(i)) : br_op_t'(3'($urandom_range(0, 7)));
            src = PHY_W'($urandom_range(1, 31));
            rs2 = ($urandom_range(0, 3) == 0) ? src : PHY_W'($urandom_range(1, 31));
            rd  = ((op == OP_JAL) || (op == OP_JALR)) ? PHY_W'(32 + i) : '0;
            dispatch_branch(op, src, rs2, rd, id_a);
        end
        wait_drain();
        finish_test(1, "all opcodes with ready operands");

        // link into 53 and a copy of it into 54 from outside
        dispatch_branch(OP_JAL, '0, '0, 6'd53, id_a);
        reg_val[54] = reg_val[53];
        ext_write(6'd54, reg_val[54]);
        dispatch_branch(OP_BEQ, 6'd53, 6'd54, '0, id_a);
        dispatch_branch(OP_JALR, 6'd53, '0, 6'd55, id_a);
        dispatch_branch(OP_BNE, 6'd55, 6'd54, '0, id_a);
        wait_drain();
        finish_test(2, "link value read by later branches");

        reg_val[51] = $urandom;
        claim_register(6'd51);
        dispatch_branch(OP_JALR, 6'd51, '0, 6'd52, id_a);
        dispatch_branch(OP_BLT, PHY_W'($urandom_range(1, 31)), 6'd51, '0, id_b);
        repeat (4) @(posedge clk);
        assert (exp_pending[id_a] && exp_pending[id_b]) else begin
            $display("branch resolved before its source register was written");
            errors++;
        end
        @(negedge clk);
        ext_write(6'd51, reg_val[51]);
        wait_drain();
        finish_test(3, "wakeup through external write");

        seen_start  = results_seen;
        reg_val[50] = $urandom;
        claim_register(6'd50);
        for (int i = 0; i <= RS_DEPTH; i++) begin
            op = br_op_t'(3'($urandom_range(0, 5)));
            dispatch_branch(op, 6'd50, PHY_W'($urandom_range(1, 31)), '0, id_a);
        end
        // station full and one more parked in dispatch
        assert (!in_ready) else begin
            $display("FAILED in_ready: got %h, expected %h", in_ready, 1'b0);
            errors++;
        end
        fork
            dispatch_branch(OP_BGEU, PHY_W'($urandom_range(1, 31)), 6'd50, '0, id_b);
            begin
                repeat (3) @(negedge clk);
                assert (!in_ready) else begin
                    $display("FAILED in_ready: got %h, expected %h", in_ready, 1'b0);
                    errors++;
                end
                ext_write(6'd50, reg_val[50]);
            end
        join
        wait_drain();
        assert ((results_seen - seen_start) == (RS_DEPTH + 3)) else begin
            $display("FAILED result count: got %h, expected %h",
                     results_seen - seen_start, RS_DEPTH + 3);
            errors++;
        end
        finish_test(4, "full station drains");

        reg_val[56] = $urandom;
        claim_register(6'd56);
        dispatch_branch(OP_BGE, 6'd56, PHY_W'($urandom_range(1, 31)), '0, id_a);
        dispatch_branch(OP_BLTU, PHY_W'($urandom_range(1, 31)),
                        PHY_W'($urandom_range(1, 31)), '0, id_b);
        wait_result(id_b);
        @(posedge clk);
        assert (exp_pending[id_a]) else begin
            $display("older waiting branch resolved ahead of its operand");
            errors++;
        end
        @(negedge clk);
        ext_write(6'd56, reg_val[56]);
        wait_drain();
        finish_test(5, "ready younger entry issues first");

        $display("%0d tests run, %0d ok, %0d with errors, %0d errors in total",
                 NUM_TESTS, tests_passed, tests_failed, errors);
        if ((errors == 0) && (tests_failed == 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

//--- br_unit_assertions.sv
`timescale 1ns/1ps

module br_unit_assertions (
    input logic            clk,
    input logic            rst,
    input logic            in_valid,
    input logic            in_ready,
    input logic            push_valid,
    input logic            push_ready,
    input br_pkg::br_uop_t push_uop,
    input logic            issue_valid,
    input logic            res_valid
);

    // set once anything has entered dispatch since reset
    logic seen_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_accept <= 1'b0;
        end else if (in_valid && in_ready) begin
            seen_accept <= 1'b1;
        end
    end

    no_early_issue: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> seen_accept)
        else $error("issue strobe with no instruction accepted since reset");

    res_after_issue: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> $past(issue_valid))
        else $error("result without an issue in the prior cycle");

    // a stalled micro-op stays put in dispatch
    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        (push_valid && !push_ready) |=>
            (push_valid && (push_uop.rob_id == $past(push_uop.rob_id))))
        else $error("micro-op left dispatch while the station was full");

endmodule

bind br_unit_top br_unit_assertions i_br_unit_assertions (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .push_valid  (ds_rs_if.valid),
    .push_ready  (ds_rs_if.ready),
    .push_uop    (ds_rs_if.uop),
    .issue_valid (issue_if.valid),
    .res_valid   (res_valid)
);

//--- br_unit_top.sv
`timescale 1ns/1ps

module br_unit_top #(
    parameter int PHYS_REGS = 64,
    parameter int RS_DEPTH  = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  br_pkg::br_uop_t               in_uop,
    output logic                          in_ready,
    input  logic                          ext_wr_valid,
    input  logic [br_pkg::PHY_W-1:0]      ext_wr_phy,
    input  logic [br_pkg::XLEN-1:0]       ext_wr_value,
    output logic                          res_valid,
    output logic [br_pkg::ROB_ID_W-1:0]   res_rob_id,
    output logic                          res_taken,
    output logic [br_pkg::XLEN-1:0]       res_target,
    output logic                          res_mispredict
);
    import br_pkg::*;

    if (PHYS_REGS > (2 ** PHY_W)) begin : g_phys_regs_check
        $error("PHYS_REGS %0d does not fit in PHY_W %0d bits", PHYS_REGS, PHY_W);
    end

    //////////////////////////////////////////////////////////////////////
    // common data bus, lane 0 external, lane 1 branch unit
    //////////////////////////////////////////////////////////////////////

    logic [CDB_WIDTH-1:0]            cdb_valid;
    logic [CDB_WIDTH-1:0][PHY_W-1:0] cdb_phy;
    logic [CDB_WIDTH-1:0][XLEN-1:0]  cdb_value;

    assign cdb_valid[0] = ext_wr_valid;
    assign cdb_phy[0]   = ext_wr_phy;
    assign cdb_value[0] = ext_wr_value;

    logic [PHY_W-1:0] rd1_phy;
    logic [PHY_W-1:0] rd2_phy;
    logic [XLEN-1:0]  rd1_value;
    logic [XLEN-1:0]  rd2_value;

    rs_dispatch_itf ds_rs_if ();
    br_issue_itf    issue_if ();

    br_dispatch #(
        .PHYS_REGS (PHYS_REGS)
    ) i_br_dispatch (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .in_ready  (in_ready),
        .cdb_valid (cdb_valid),
        .cdb_phy   (cdb_phy),
        .to_rs     (ds_rs_if.dispatch)
    );

    br_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) i_br_rs (
        .clk       (clk),
        .rst       (rst),
        .from_ds   (ds_rs_if.rs),
        .cdb_valid (cdb_valid),
        .cdb_phy   (cdb_phy),
        .rd1_phy   (rd1_phy),
        .rd2_phy   (rd2_phy),
        .rd1_value (rd1_value),
        .rd2_value (rd2_value),
        .to_fu     (issue_if.rs)
    );

    phys_regfile #(
        .PHYS_REGS (PHYS_REGS)
    ) i_phys_regfile (
        .clk       (clk),
        .rst       (rst),
        .rd1_phy   (rd1_phy),
        .rd2_phy   (rd2_phy),
        .rd1_value (rd1_value),
        .rd2_value (rd2_value),
        .cdb_valid (cdb_valid),
        .cdb_phy   (cdb_phy),
        .cdb_value (cdb_value)
    );

    fu_br i_fu_br (
        .clk            (clk),
        .rst            (rst),
        .from_rs        (issue_if.fu),
        .res_valid      (res_valid),
        .res_rob_id     (res_rob_id),
        .res_taken      (res_taken),
        .res_target     (res_target),
        .res_mispredict (res_mispredict),
        .cdb_valid      (cdb_valid[1]),
        .cdb_phy        (cdb_phy[1]),
        .cdb_value      (cdb_value[1])
    );

endmodule

//--- phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile #(
    parameter int PHYS_REGS = 64
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [br_pkg::PHY_W-1:0]                  rd1_phy,
    input  logic [br_pkg::PHY_W-1:0]                  rd2_phy,
    output logic [br_pkg::XLEN-1:0]                   rd1_value,
    output logic [br_pkg::XLEN-1:0]                   rd2_value,
    input  logic [br_pkg::CDB_WIDTH-1:0]              cdb_valid,
    input  logic [br_pkg::CDB_WIDTH-1:0][br_pkg::PHY_W-1:0] cdb_phy,
    input  logic [br_pkg::CDB_WIDTH-1:0][br_pkg::XLEN-1:0]  cdb_value
);
    import br_pkg::*;

    logic [XLEN-1:0]  regs [PHYS_REGS];
    logic [PHY_W-1:0] rd_phy [2];
    logic [XLEN-1:0]  rd_val [2];

    // writes are held off while in reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k] && (cdb_phy[k] != '0)) begin
                    regs[cdb_phy[k]] <= cdb_value[k];
                end
            end
        end
    end

    assign rd_phy[0] = rd1_phy;
    assign rd_phy[1] = rd2_phy;
    assign rd1_value = rd_val[0];
    assign rd2_value = rd_val[1];

    // write-through, higher lane wins on a clash
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_val[p] = regs[rd_phy[p]];
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k] && (cdb_phy[k] == rd_phy[p])) begin
                    rd_val[p] = cdb_value[k];
                end
            end
            if (rd_phy[p] == '0) begin
                rd_val[p] = '0;
            end
        end
    end

endmodule

//--- fu_br.sv
`timescale 1ns/1ps

module fu_br (
    input  logic                          clk,
    input  logic                          rst,
    br_issue_itf.fu                       from_rs,
    output logic                          res_valid,
    output logic [br_pkg::ROB_ID_W-1:0]   res_rob_id,
    output logic                          res_taken,
    output logic [br_pkg::XLEN-1:0]       res_target,
    output logic                          res_mispredict,
    output logic                          cdb_valid,
    output logic [br_pkg::PHY_W-1:0]      cdb_phy,
    output logic [br_pkg::XLEN-1:0]       cdb_value
);
    import br_pkg::*;

    br_uop_t         uop;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] jalr_sum;
    logic            taken;
    logic [XLEN-1:0] target;
    logic            is_link;
    logic            mispredict;

    assign uop      = from_rs.uop;
    assign a        = from_rs.rs1_value;
    assign b        = from_rs.rs2_value;
    assign jalr_sum = a + uop.imm;

    always_comb begin
        taken   = 1'b0;
        is_link = 1'b0;
        target  = uop.pc + uop.imm;
        case (uop.op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            OP_BGE:  taken = ($signed(a) >= $signed(b));
            OP_BLTU: taken = (a < b);
            OP_BGEU: taken = (a >= b);
            OP_JAL: begin
                taken   = 1'b1;
                is_link = 1'b1;
            end
            OP_JALR: begin
                taken   = 1'b1;
                is_link = 1'b1;
                target  = {jalr_sum[XLEN-1:1], 1'b0};
            end
            default: taken = 1'b0;
        endcase
    end

    // a wrong target only matters when the branch goes
    assign mispredict = (taken != uop.predict_taken) ||
                        (taken && (target != uop.predict_target));

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            res_valid <= from_rs.valid;
            cdb_valid <= from_rs.valid && is_link;
        end
    end

    always_ff @(posedge clk) begin
        if (from_rs.valid) begin
            res_rob_id     <= uop.rob_id;
            res_taken      <= taken;
            res_target     <= target;
            res_mispredict <= mispredict;
            cdb_phy        <= uop.rd_phy;
            cdb_value      <= uop.pc + XLEN'(4);
        end
    end

endmodule

//--- br_rs.sv
`timescale 1ns/1ps

module br_rs #(
    parameter int RS_DEPTH = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    rs_dispatch_itf.rs                                from_ds,
    input  logic [br_pkg::CDB_WIDTH-1:0]              cdb_valid,
    input  logic [br_pkg::CDB_WIDTH-1:0][br_pkg::PHY_W-1:0] cdb_phy,
    output logic [br_pkg::PHY_W-1:0]                  rd1_phy,
    output logic [br_pkg::PHY_W-1:0]                  rd2_phy,
    input  logic [br_pkg::XLEN-1:0]                   rd1_value,
    input  logic [br_pkg::XLEN-1:0]                   rd2_value,
    br_issue_itf.rs                                   to_fu
);
    import br_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////////////////////////

    br_uop_t              entry [RS_DEPTH];
    logic [RS_DEPTH-1:0]  used;
    logic [RS_DEPTH-1:0]  entry_ready;

    logic                 push_en;
    logic [IDX_W-1:0]     push_idx;
    br_uop_t              push_uop;

    logic                 issue_en;
    logic [IDX_W-1:0]     issue_idx;

    assign from_ds.ready = ~&used;

    always_ff @(posedge clk) begin
        if (rst) begin
            used <= '0;
        end else begin
            if (push_en) begin
                used[push_idx] <= 1'b1;
            end
            // issue frees its slot, never the one being pushed
            if (issue_en) begin
                used[issue_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wakeup of resident entries
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (used[i]) begin
                if (cdb_hit(cdb_valid, cdb_phy, entry[i].rs1_phy)) begin
                    entry[i].rs1_ready <= 1'b1;
                end
                if (cdb_hit(cdb_valid, cdb_phy, entry[i].rs2_phy)) begin
                    entry[i].rs2_ready <= 1'b1;
                end
            end
        end
        if (push_en) begin
            entry[push_idx] <= push_uop;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // allocation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        push_uop           = from_ds.uop;
        push_uop.rs1_ready = from_ds.uop.rs1_ready ||
                             cdb_hit(cdb_valid, cdb_phy, from_ds.uop.rs1_phy);
        push_uop.rs2_ready = from_ds.uop.rs2_ready ||
                             cdb_hit(cdb_valid, cdb_phy, from_ds.uop.rs2_phy);
    end

    // lowest free slot
    always_comb begin
        push_en  = 1'b0;
        push_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!push_en && !used[i] && from_ds.valid) begin
                push_en  = 1'b1;
                push_idx = IDX_W'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // issue select, with same cycle cdb bypass
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entry_ready[i] = used[i] &&
                (entry[i].rs1_ready || cdb_hit(cdb_valid, cdb_phy, entry[i].rs1_phy)) &&
                (entry[i].rs2_ready || cdb_hit(cdb_valid, cdb_phy, entry[i].rs2_phy));
        end
    end

    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!issue_en && entry_ready[i]) begin
                issue_en  = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    // operands come back from the register file in the same cycle
    assign rd1_phy = entry[issue_idx].rs1_phy;
    assign rd2_phy = entry[issue_idx].rs2_phy;

    assign to_fu.valid     = issue_en;
    assign to_fu.uop       = entry[issue_idx];
    assign to_fu.rs1_value = rd1_value;
    assign to_fu.rs2_value = rd2_value;

endmodule

//--- br_dispatch.sv
`timescale 1ns/1ps

module br_dispatch #(
    parameter int PHYS_REGS = 64
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      in_valid,
    input  br_pkg::br_uop_t                           in_uop,
    output logic                                      in_ready,
    input  logic [br_pkg::CDB_WIDTH-1:0]              cdb_valid,
    input  logic [br_pkg::CDB_WIDTH-1:0][br_pkg::PHY_W-1:0] cdb_phy,
    rs_dispatch_itf.dispatch                          to_rs
);
    import br_pkg::*;

    // one bit per physical register, set while a result is pending
    logic [PHYS_REGS-1:0] busy;

    logic    hold_valid;
    br_uop_t hold_uop;
    logic    accept;

    assign in_ready = !hold_valid || to_rs.ready;
    assign accept   = in_valid && in_ready;

    assign to_rs.valid = hold_valid;
    assign to_rs.uop   = hold_uop;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            busy       <= '0;
        end else begin
            // writeback clears first so a new producer of the same reg wins
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k]) begin
                    busy[cdb_phy[k]] <= 1'b0;
                end
            end
            if (accept && (in_uop.rd_phy != '0)) begin
                busy[in_uop.rd_phy] <= 1'b1;
            end

            if (accept) begin
                hold_valid <= 1'b1;
            end else if (to_rs.ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_uop           <= in_uop;
            hold_uop.rs1_ready <= !busy[in_uop.rs1_phy] ||
                                  cdb_hit(cdb_valid, cdb_phy, in_uop.rs1_phy);
            hold_uop.rs2_ready <= !busy[in_uop.rs2_phy] ||
                                  cdb_hit(cdb_valid, cdb_phy, in_uop.rs2_phy);
        end else if (hold_valid) begin
            // keep snooping while waiting for a station slot
            if (cdb_hit(cdb_valid, cdb_phy, hold_uop.rs1_phy)) begin
                hold_uop.rs1_ready <= 1'b1;
            end
            if (cdb_hit(cdb_valid, cdb_phy, hold_uop.rs2_phy)) begin
                hold_uop.rs2_ready <= 1'b1;
            end
        end
    end

endmodule

//--- br_issue_itf.sv
`timescale 1ns/1ps

interface br_issue_itf;
    import br_pkg::*;

    // single cycle strobe, no back-pressure
    logic            valid;
    br_uop_t         uop;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;

    modport rs (
        output valid,
        output uop,
        output rs1_value,
        output rs2_value
    );

    modport fu (
        input valid,
        input uop,
        input rs1_value,
        input rs2_value
    );

endinterface

//--- rs_dispatch_itf.sv
`timescale 1ns/1ps

interface rs_dispatch_itf;
    import br_pkg::*;

    br_uop_t uop;
    logic    valid;
    logic    ready;

    // dispatch side drives the micro-op
    modport dispatch (
        output uop,
        output valid,
        input  ready
    );

    modport rs (
        input  uop,
        input  valid,
        output ready
    );

endinterface

//--- br_pkg.sv
package br_pkg;

    // data, tag and register index widths
    localparam int XLEN      = 32;
    localparam int ROB_ID_W  = 5;
    localparam int PHY_W     = 6;

    // lane 0 external writeback, lane 1 branch unit
    localparam int CDB_WIDTH = 2;

    typedef enum logic [2:0] {
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR
    } br_op_t;

    typedef struct packed {
        logic [ROB_ID_W-1:0] rob_id;
        br_op_t              op;
        logic [PHY_W-1:0]    rs1_phy;
        logic                rs1_ready;
        logic [PHY_W-1:0]    rs2_phy;
        logic                rs2_ready;
        logic [PHY_W-1:0]    rd_phy;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     imm;
        logic                predict_taken;
        logic [XLEN-1:0]     predict_target;
    } br_uop_t;

    // true when any cdb lane writes reg_phy this cycle
    function automatic logic cdb_hit(
        input logic [CDB_WIDTH-1:0]            valid,
        input logic [CDB_WIDTH-1:0][PHY_W-1:0] phy,
        input logic [PHY_W-1:0]                reg_phy
    );
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (valid[k] && (phy[k] == reg_phy)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage
